// ==== Bender.yml ====
package:
  name: masked_decode

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/masked_decode_pkg.sv
      - hw/mask_prng.sv
      - hw/coeff_dispatch.sv
      - hw/masked_bit_decode.sv
      - hw/msg_pack.sv
      - hw/masked_decode_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_clock_gen.sv
      - sim/tb_masked_decode.sv

// ==== flist.f ====
+incdir+include
hw/masked_decode_pkg.sv
hw/mask_prng.sv
hw/coeff_dispatch.sv
hw/masked_bit_decode.sv
hw/msg_pack.sv
hw/masked_decode_top.sv
sim/tb_clock_gen.sv
sim/tb_masked_decode.sv

// ==== hw/coeff_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "masked_decode_settings.svh"

module coeff_dispatch (
  input  wire                                      clk,
  input  wire                                      rst,
  input  wire                                      start,
  input  wire                                      coeff_valid,
  input  wire  masked_decode_pkg::coeff_t          coeff_a,
  input  wire  masked_decode_pkg::coeff_t          coeff_b,
  output logic                                     lane_go,
  output masked_decode_pkg::coeff_t [`N_LANES-1:0] lane_a,
  output masked_decode_pkg::coeff_t [`N_LANES-1:0] lane_b
);

  localparam int            CW   = $clog2(`N_LANES);
  localparam logic [CW-1:0] LAST = CW'(`N_LANES - 1);

  // Slot counter
  logic [CW-1:0] cnt;
  logic [CW-1:0] slot;
  logic          fire;

  // Staging registers and their next value
  masked_decode_pkg::coeff_t [`N_LANES-1:0] stage_a;
  masked_decode_pkg::coeff_t [`N_LANES-1:0] stage_b;
  masked_decode_pkg::coeff_t [`N_LANES-1:0] next_a;
  masked_decode_pkg::coeff_t [`N_LANES-1:0] next_b;

  ////////////////////////////////////////////////////////////
  // Slot select
  ////////////////////////////////////////////////////////////

  always_comb begin
    // A coefficient arriving with start is slot 0 of the new message
    slot   = start ? '0 : cnt;
    fire   = coeff_valid && (slot == LAST);
    next_a = stage_a;
    next_b = stage_b;
    if (coeff_valid) begin
      next_a[slot] = coeff_a;
      next_b[slot] = coeff_b;
    end
  end

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt     <= '0;
      lane_go <= 1'b0;
    end else begin
      // Launch one cycle after the last slot fills
      lane_go <= fire;
      if (coeff_valid) begin
        cnt <= fire ? '0 : slot + 1'b1;
      end else if (start) begin
        cnt <= '0;
      end
    end
  end

  // Staging and batch output
  always_ff @(posedge clk) begin
    stage_a <= next_a;
    stage_b <= next_b;
    // Batch includes the share pair taken this cycle
    if (fire) begin
      lane_a <= next_a;
      lane_b <= next_b;
    end
  end

endmodule

`default_nettype wire

// ==== hw/mask_prng.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "masked_decode_settings.svh"

module mask_prng (
  input  wire                                     clk,
  input  wire                                     rst,
  output masked_decode_pkg::rand_t [`N_LANES-1:0] rand_words
);

  // One full word per lane per cycle
  localparam int SW = `N_LANES * `COEFF_W;

  logic [SW-1:0] state;

  // Advance the register by its own width
  // so every output bit is replaced each cycle
  function automatic logic [SW-1:0] lfsr_advance(input logic [SW-1:0] s);
    logic [SW-1:0] t;
    logic          fb;
    t = s;
    for (int k = 0; k < SW; k++) begin
      // Taps 64 63 61 60, maximal length
      fb = t[SW-1] ^ t[SW-2] ^ t[SW-4] ^ t[SW-5];
      t  = {t[SW-2:0], fb};
    end
    return t;
  endfunction

  ////////////////////////////////////////////////////////////
  // State register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= SW'(`PRNG_SEED);
    end else begin
      state <= lfsr_advance(state);
    end
  end

  // Disjoint slices, lane i gets bits 16i and up
  assign rand_words = state;

endmodule

`default_nettype wire

// ==== hw/masked_bit_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "masked_decode_settings.svh"

module masked_bit_decode (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            go,
  input  wire masked_decode_pkg::coeff_t share_a,
  input  wire masked_decode_pkg::coeff_t share_b,
  input  wire masked_decode_pkg::rand_t  rand_word,
  output logic                           bit_valid,
  output logic                           bit_a,
  output logic                           bit_b
);

  localparam int           W    = `QBITS2;
  localparam int           K    = `LANE_LATENCY;
  localparam logic [W-1:0] Q_M  = W'(`KYBER_Q);
  localparam logic [W-1:0] LO_M = W'(`DEC_LO);
  localparam logic [W-1:0] HI_M = W'(`DEC_HI);

  // Masked sign of u + v mod 2^W
  // u and v are held by different shares, carry stays Boolean-shared
  // Carry is maj(u, v, c) = ((u ^ c) & (v ^ c)) ^ c, one ISW AND per bit
  function automatic logic [1:0] masked_msb(
    input logic [W-1:0] u,
    input logic [W-1:0] v,
    input logic [W-2:0] r
  );
    logic ca;
    logic cb;
    logic xa;
    logic xb;
    logic ya;
    logic yb;
    logic za;
    logic zb;
    ca = 1'b0;
    cb = 1'b0;
    for (int i = 0; i < W - 1; i++) begin
      // Shares of u ^ c and v ^ c
      xa = u[i] ^ ca;
      xb = cb;
      ya = ca;
      yb = v[i] ^ cb;
      // ISW AND refreshed by r[i]
      za = (xa & ya) ^ r[i];
      zb = (xb & yb) ^ ((r[i] ^ (xa & yb)) ^ (xb & ya));
      ca = za ^ ca;
      cb = zb ^ cb;
    end
    return {u[W-1] ^ ca, v[W-1] ^ cb};
  endfunction

  // One-hot valid pipe
  logic [K-1:0] valid_sr;

  // Stage registers
  logic [W-1:0] s0_y1;
  logic [W-1:0] s0_y2;
  logic [W-1:0] s1_y1;
  logic [W-1:0] s1_y2;
  logic         s1_k1;
  logic         s1_k2;
  logic [W-1:0] s2_y1;
  logic [W-1:0] s2_y2;
  logic         s2_k1;
  logic [W-1:0] s2_t1;
  logic [W-1:0] s2_t2;
  logic [W-1:0] s3_c1;
  logic [W-1:0] s3_c2;
  logic         s4_lo_a;
  logic         s4_lo_b;
  logic         s4_hi_a;
  logic         s4_hi_b;

  // Last cycle's random word, unused by the item now in stage 4
  masked_decode_pkg::rand_t rand_q;

  // Masked sign bit sharings
  logic [1:0] wrap_sh;
  logic [1:0] lo_sh;
  logic [1:0] hi_sh;

  assign bit_valid = valid_sr[K-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[K-2:0], go};
    end
  end

  always_ff @(posedge clk) begin
    rand_q <= rand_word;
  end

  ////////////////////////////////////////////////////////////
  // Stage 0 to 3, sharing mod q to sharing mod 2^13
  ////////////////////////////////////////////////////////////

  // Share sum minus q is negative when no wrap happened
  assign wrap_sh = masked_msb(s0_y1 - Q_M, s0_y2, rand_word[W-2:0]);

  always_ff @(posedge clk) begin
    // Re-split with a fresh mask, mask removed from share a first
    if (go) begin
      s0_y1 <= rand_word[W-1:0];
      s0_y2 <= (share_a[W-1:0] - rand_word[W-1:0]) + share_b[W-1:0];
    end
    // Wrap bit w = k1 ^ k2
    if (valid_sr[0]) begin
      s1_y1 <= s0_y1;
      s1_y2 <= s0_y2;
      s1_k1 <= ~wrap_sh[1];
      s1_k2 <= wrap_sh[0];
    end
    // Share b side of q * k2, masked by R
    if (valid_sr[1]) begin
      s2_y1 <= s1_y1;
      s2_y2 <= s1_y2;
      s2_k1 <= s1_k1;
      s2_t1 <= rand_word[`COEFF_W-1 -: W];
      s2_t2 <= (s1_k2 ? Q_M : '0) - rand_word[`COEFF_W-1 -: W];
    end
    // q * w = q * k1 + s * q * k2 with s = 1 - 2 * k1
    if (valid_sr[2]) begin
      s3_c1 <= s2_k1 ? (s2_y1 - Q_M + s2_t1) : (s2_y1 - s2_t1);
      s3_c2 <= s2_k1 ? (s2_y2 + s2_t2) : (s2_y2 - s2_t2);
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 4 and 5, threshold tests
  ////////////////////////////////////////////////////////////

  // Sign set means coefficient below the threshold
  assign lo_sh = masked_msb(s3_c1 - LO_M, s3_c2, rand_word[`COEFF_W-1 -: W-1]);
  assign hi_sh = masked_msb(s3_c1 - HI_M, s3_c2, rand_q[W-2:0]);

  always_ff @(posedge clk) begin
    if (valid_sr[3]) begin
      s4_lo_a <= lo_sh[1];
      s4_lo_b <= lo_sh[0];
      s4_hi_a <= hi_sh[1];
      s4_hi_b <= hi_sh[0];
    end
    // Low sign implies high sign so XOR gives the band test
    if (valid_sr[4]) begin
      bit_a <= (s4_lo_a ^ rand_word[0]) ^ s4_hi_a;
      bit_b <= (s4_lo_b ^ rand_word[0]) ^ s4_hi_b;
    end
  end

endmodule

`default_nettype wire

// ==== hw/masked_decode_pkg.sv ====
`default_nettype none

`include "masked_decode_settings.svh"

package masked_decode_pkg;

  ////////////////////////////////////////////////////////////
  // Datapath types
  ////////////////////////////////////////////////////////////

  // One arithmetic share of a coefficient mod q
  typedef logic [`COEFF_W-1:0] coeff_t;

  // Fresh random word for one lane
  typedef logic [`COEFF_W-1:0] rand_t;

  // One decoded bit share per lane
  typedef logic [`N_LANES-1:0] batch_t;

  // One Boolean share of a message byte
  typedef logic [7:0] msg_byte_t;

endpackage

`default_nettype wire

// ==== hw/masked_decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "masked_decode_settings.svh"

module masked_decode_top (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               start,
  input  wire                               coeff_valid,
  input  wire  masked_decode_pkg::coeff_t   coeff_a,
  input  wire  masked_decode_pkg::coeff_t   coeff_b,
  output logic                              msg_valid,
  output masked_decode_pkg::msg_byte_t      msg_a,
  output masked_decode_pkg::msg_byte_t      msg_b
);

  // Fresh randomness, one word per lane
  masked_decode_pkg::rand_t [`N_LANES-1:0] rand_words;

  // Batch launch
  logic                                     lane_go;
  masked_decode_pkg::coeff_t [`N_LANES-1:0] lane_a;
  masked_decode_pkg::coeff_t [`N_LANES-1:0] lane_b;

  // Lane results
  masked_decode_pkg::batch_t lane_valid;
  masked_decode_pkg::batch_t bits_a;
  masked_decode_pkg::batch_t bits_b;

  mask_prng u_mask_prng (
    .clk        (clk),
    .rst        (rst),
    .rand_words (rand_words)
  );

  coeff_dispatch u_coeff_dispatch (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .coeff_valid (coeff_valid),
    .coeff_a     (coeff_a),
    .coeff_b     (coeff_b),
    .lane_go     (lane_go),
    .lane_a      (lane_a),
    .lane_b      (lane_b)
  );

  ////////////////////////////////////////////////////////////
  // Masked lanes, all launched together
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `N_LANES; i++) begin : g_lane
    masked_bit_decode u_lane (
      .clk       (clk),
      .rst       (rst),
      .go        (lane_go),
      .share_a   (lane_a[i]),
      .share_b   (lane_b[i]),
      .rand_word (rand_words[i]),
      .bit_valid (lane_valid[i]),
      .bit_a     (bits_a[i]),
      .bit_b     (bits_b[i])
    );
  end

  // Lanes run in lockstep, lane 0 strobe stands for the batch
  msg_pack u_msg_pack (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .batch_valid (lane_valid[0]),
    .batch_a     (bits_a),
    .batch_b     (bits_b),
    .msg_valid   (msg_valid),
    .msg_a       (msg_a),
    .msg_b       (msg_b)
  );

endmodule

`default_nettype wire

// ==== hw/msg_pack.sv ====
`timescale 1ns/1ps
`default_nettype none

module msg_pack (
  input  wire                               clk,
  input  wire                               rst,
  input  wire                               start,
  input  wire                               batch_valid,
  input  wire  masked_decode_pkg::batch_t   batch_a,
  input  wire  masked_decode_pkg::batch_t   batch_b,
  output logic                              msg_valid,
  output masked_decode_pkg::msg_byte_t      msg_a,
  output masked_decode_pkg::msg_byte_t      msg_b
);

  // Low nibble held
  logic half;

  // Low nibble shares
  masked_decode_pkg::batch_t lo_a;
  masked_decode_pkg::batch_t lo_b;

  ////////////////////////////////////////////////////////////
  // Byte half tracking
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      half      <= 1'b0;
      msg_valid <= 1'b0;
    end else begin
      msg_valid <= 1'b0;
      // Batch seen with start belongs to the old message
      if (start) begin
        half <= 1'b0;
      end else if (batch_valid) begin
        half      <= ~half;
        msg_valid <= half;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Byte assembly, LSB first
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (batch_valid && !half) begin
      lo_a <= batch_a;
      lo_b <= batch_b;
    end
    // Second batch is the high nibble
    if (batch_valid && half) begin
      msg_a <= {batch_a, lo_a};
      msg_b <= {batch_b, lo_b};
    end
  end

endmodule

`default_nettype wire

// ==== include/masked_decode_settings.svh ====
`ifndef MASKED_DECODE_SETTINGS_SVH
`define MASKED_DECODE_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Arithmetic
////////////////////////////////////////////////////////////

// Kyber modulus q
`define KYBER_Q 3329

// Width of one arithmetic share
`define COEFF_W 16

// Lanes work modulo 2^13
`define QBITS2 13

////////////////////////////////////////////////////////////
// Structure and timing
////////////////////////////////////////////////////////////

// Coefficients decoded side by side
`define N_LANES 4

// Launch to bit_valid in cycles
`define LANE_LATENCY 6

// One-band is DEC_LO up to DEC_HI - 1
`define DEC_LO 833
`define DEC_HI 2497

// LFSR start state, must be nonzero
`define PRNG_SEED 64'hC3A5_1F7E_9B24_6D81

`endif

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  // 40 ns period
  initial clk = 1'b0;
  always #20 clk = ~clk;

  // Reset held over five rising edges, released just after the fifth
  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== sim/tb_masked_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "masked_decode_settings.svh"

module tb_masked_decode;

  // Cycles from coefficient accept to msg_valid
  localparam int PATH_LAT      = 8;
  localparam int DRAIN_TIMEOUT = 200;
  localparam int RESET_TIMEOUT = 20;

  logic                         clk;
  logic                         rst;
  logic                         start;
  logic                         coeff_valid;
  masked_decode_pkg::coeff_t    coeff_a;
  masked_decode_pkg::coeff_t    coeff_b;
  logic                         msg_valid;
  masked_decode_pkg::msg_byte_t msg_a;
  masked_decode_pkg::msg_byte_t msg_b;

  // Stimulus LFSR apart from the DUT PRNG
  logic [15:0] lfsr = 16'd5;
  // Rising edges seen so far
  int cyc = 0;

  // Expected bytes and their arrival cycles
  masked_decode_pkg::msg_byte_t exp_bytes [$];
  int                           exp_cycles [$];
  masked_decode_pkg::msg_byte_t acc;
  int                           nbit;

  // Share observations per decoded value
  bit                           track_mask;
  bit                           mask_varied;
  bit                           seen_val [256];
  masked_decode_pkg::msg_byte_t first_a [256];

  tb_clock_gen u_clock_gen (
    .clk (clk),
    .rst (rst)
  );

  masked_decode_top u_masked_decode_top (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .coeff_valid (coeff_valid),
    .coeff_a     (coeff_a),
    .coeff_b     (coeff_b),
    .msg_valid   (msg_valid),
    .msg_a       (msg_a),
    .msg_b       (msg_b)
  );

  always @(posedge clk) cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////
  // Random numbers and decode rule
  ////////////////////////////////////////////////////////////

  // Taps 16 14 13 11 and one step per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | lfsr_bit();
    end
    return v;
  endfunction

  function automatic int rand_mod_q();
    return rand_bits(16) % `KYBER_Q;
  endfunction

  // One-band of round(2c/q) mod 2
  function automatic logic ref_bit(input int c);
    return (c >= `DEC_LO) && (c < `DEC_HI);
  endfunction

  // Directed values around both thresholds
  function automatic int thr_coeff(input int k);
    case (k)
      0:       return 832;
      1:       return 833;
      2:       return 2496;
      default: return 2497;
    endcase
  endfunction

  // Known decode of the directed values
  function automatic logic thr_bit(input int k);
    return (k == 1) || (k == 2);
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input masked_decode_pkg::msg_byte_t got,
                            input masked_decode_pkg::msg_byte_t exp);
    if (got !== exp) begin
      fail_stop($sformatf("CHECK FAILED %s got 0x%02h expected 0x%02h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_stop($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // First msg_a per value kept for later compares
  task automatic record_mask(input masked_decode_pkg::msg_byte_t v,
                             input masked_decode_pkg::msg_byte_t a);
    if (seen_val[v] && (first_a[v] != a)) begin
      mask_varied = 1'b1;
    end else if (!seen_val[v]) begin
      seen_val[v] = 1'b1;
      first_a[v]  = a;
    end
  endtask

  // Strobe compared on every edge against the next expected arrival
  always begin : monitor
    logic exp_v;
    @(posedge clk);
    #1;
    exp_v = (exp_cycles.size() > 0) && (exp_cycles[0] == cyc);
    check_bit("msg_valid", msg_valid, exp_v);
    if (exp_v) begin
      check_byte("msg_a ^ msg_b", msg_a ^ msg_b, exp_bytes[0]);
      if (track_mask) begin
        record_mask(exp_bytes[0], msg_a);
      end
      void'(exp_bytes.pop_front());
      void'(exp_cycles.pop_front());
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Random sharing of c with its expected bit appended LSB first
  task automatic send_sharing(input int c, input logic exp_bit);
    int a;
    a = rand_mod_q();
    @(posedge clk);
    #2;
    start       = 1'b0;
    coeff_valid = 1'b1;
    coeff_a     = masked_decode_pkg::coeff_t'(a);
    coeff_b     = masked_decode_pkg::coeff_t'((c - a + `KYBER_Q) % `KYBER_Q);
    acc[nbit]   = exp_bit;
    nbit++;
    if (nbit == 8) begin
      exp_bytes.push_back(acc);
      exp_cycles.push_back(cyc + PATH_LAT);
      nbit = 0;
    end
  endtask

  // Model bit from the decode rule
  task automatic drive_coeff(input int c);
    send_sharing(c, ref_bit(c));
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
      start       = 1'b0;
      coeff_valid = 1'b0;
    end
  endtask

  // Partial byte in the model is dropped as the DUT drops it
  task automatic pulse_start();
    @(posedge clk);
    #2;
    start       = 1'b1;
    coeff_valid = 1'b0;
    acc         = '0;
    nbit        = 0;
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_bytes.size() != 0) begin
      if (n >= DRAIN_TIMEOUT) begin
        fail_stop("Timeout: expected bytes never arrived on msg_valid");
      end else begin
        @(posedge clk);
        n++;
      end
    end
  endtask

  task automatic wait_reset_done();
    int n;
    n = 0;
    while (rst !== 1'b0) begin
      if (n >= RESET_TIMEOUT) begin
        fail_stop("Timeout: reset was never released");
      end else begin
        @(posedge clk);
        n++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    start       = 1'b0;
    coeff_valid = 1'b0;
    coeff_a     = '0;
    coeff_b     = '0;
    acc         = '0;
    nbit        = 0;
    track_mask  = 1'b0;
    mask_varied = 1'b0;
    // Monitor keeps msg_valid low through and after reset
    wait_reset_done();
    idle(4);
    // 64 random bytes back to back
    pulse_start();
    track_mask = 1'b1;
    for (int i = 0; i < 64 * 8; i++) begin
      drive_coeff(rand_mod_q());
    end
    idle(1);
    wait_drained();
    track_mask = 1'b0;
    if (!mask_varied) begin
      fail_stop("Masking check: msg_a never differed between equal decoded bytes");
    end
    // Threshold pattern decoding to 0 1 1 0 per group
    for (int i = 0; i < 4 * 8; i++) begin
      send_sharing(thr_coeff(i % 4), thr_bit(i % 4));
    end
    idle(1);
    wait_drained();
    // Random gaps between coefficients
    for (int i = 0; i < 4 * 8; i++) begin
      drive_coeff(rand_mod_q());
      idle(rand_bits(2));
    end
    idle(1);
    wait_drained();
    // Three coefficients thrown away by start
    for (int i = 0; i < 3; i++) begin
      drive_coeff(rand_mod_q());
    end
    pulse_start();
    for (int i = 0; i < 8; i++) begin
      drive_coeff(rand_mod_q());
    end
    idle(1);
    wait_drained();
    idle(4);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire
